// ==== logic/epu_pkg.sv ====
package epu_pkg;

    // Bus field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  id_t;
    typedef logic [7:0]  len_t;
    typedef logic [1:0]  resp_t;

    // Buffer word index and element count (1 to 64)
    typedef logic [5:0]  buf_idx_t;
    typedef logic [6:0]  cnt_t;

    // Offset inside the control region
    typedef logic [15:0] reg_off_t;

    // Operands sit in the low half of each word
    typedef logic signed [15:0] elem_t;
    typedef logic signed [31:0] acc_t;

    localparam int BUF_DEPTH = 64;

    // Memory map, each region spans 64 KiB
    localparam addr_t REGION_MASK = 32'hFFFF_0000;
    localparam addr_t IN_BASE     = 32'h5000_0000;
    localparam addr_t WT_BASE     = 32'h7000_0000;
    localparam addr_t CTRL_BASE   = 32'h8000_0000;

    // Control and status registers
    localparam reg_off_t REG_LEN    = 16'h0000;
    localparam reg_off_t REG_CTRL   = 16'h0004;
    localparam reg_off_t REG_RESULT = 16'h0008;
    localparam reg_off_t REG_STATUS = 16'h000C;

    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_RELU_BIT   = 1;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    localparam resp_t RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_WR,
        S_RESP
    } slave_state_e;

    // Shared by AW and AR
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } axi_ar_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
        resp_t resp;
    } axi_r_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        buf_idx_t idx;
        data_t    wdata;
        logic     we;
    } buf_req_t;

    typedef struct packed {
        cnt_t count;
        logic relu;
    } mac_cmd_t;

endpackage

// ==== logic/epu_buffer.sv ====
module epu_buffer (
    input  logic               clk,
    // Bus side
    input  logic               sel_i,
    input  epu_pkg::buf_req_t  req_i,
    output epu_pkg::data_t     rdata_o,
    // Engine side, read only
    input  epu_pkg::buf_idx_t  eng_idx_i,
    output epu_pkg::data_t     eng_rdata_o
);

    epu_pkg::data_t mem [epu_pkg::BUF_DEPTH];

    // Bus port, write and registered read at the same index
    always_ff @(posedge clk) begin
        if (sel_i && req_i.we) begin
            mem[req_i.idx] <= req_i.wdata;
        end
        rdata_o <= mem[req_i.idx];
    end

    // Engine port reads every cycle, one cycle latency
    always_ff @(posedge clk) begin
        eng_rdata_o <= mem[eng_idx_i];
    end

endmodule

// ==== logic/mac_engine.sv ====
module mac_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  epu_pkg::mac_cmd_t cmd_i,
    // Shared index into both buffers
    output epu_pkg::buf_idx_t idx_o,
    input  epu_pkg::data_t    in_data_i,
    input  epu_pkg::data_t    wt_data_i,
    output epu_pkg::acc_t     result_o,
    output logic              busy_o,
    output logic              done_o
);

    epu_pkg::buf_idx_t idx_q;
    epu_pkg::cnt_t     left_q;
    logic              issue;
    logic              issue_last;

    // Stage valids, v1 lines up with buffer read data
    logic v1_q;
    logic last1_q;
    logic v2_q;
    logic last2_q;

    logic relu_q;
    logic busy_q;
    logic done_q;

    epu_pkg::elem_t in_elem;
    epu_pkg::elem_t wt_elem;
    epu_pkg::acc_t  prod_q;
    epu_pkg::acc_t  acc_q;
    epu_pkg::acc_t  sum;
    epu_pkg::acc_t  result_q;

    // Index 0 is already on the bus when start arrives
    assign issue      = start_i || (left_q != '0);
    assign issue_last = start_i ? (cmd_i.count == 7'd1) : (left_q == 7'd1);
    assign idx_o      = idx_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx_q  <= '0;
            left_q <= '0;
        end else if (start_i) begin
            idx_q  <= 6'd1;
            left_q <= cmd_i.count - 7'd1;
        end else if (left_q != '0) begin
            idx_q  <= idx_q + 6'd1;
            left_q <= left_q - 7'd1;
        end else begin
            idx_q <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            v1_q    <= 1'b0;
            last1_q <= 1'b0;
            v2_q    <= 1'b0;
            last2_q <= 1'b0;
        end else begin
            v1_q    <= issue;
            last1_q <= issue && issue_last;
            v2_q    <= v1_q;
            last2_q <= last1_q;
        end
    end

    assign in_elem = in_data_i[15:0];
    assign wt_elem = wt_data_i[15:0];

    // Stage 1, signed 16x16 product
    always_ff @(posedge clk) begin
        if (v1_q) begin
            prod_q <= in_elem * wt_elem;
        end
    end

    // Stage 2, accumulate with wrap
    assign sum = acc_q + prod_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc_q    <= '0;
            result_q <= '0;
            relu_q   <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
        end else if (start_i) begin
            acc_q  <= '0;
            relu_q <= cmd_i.relu;
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (v2_q) begin
            if (last2_q) begin
                acc_q    <= '0;
                result_q <= (relu_q && (sum < 0)) ? '0 : sum;
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
            end else begin
                acc_q <= sum;
            end
        end
    end

    assign result_o = result_q;
    assign busy_o   = busy_q;
    assign done_o   = done_q;

    // Length register must hold a legal count when a run starts
    a_count_legal: assert property (@(posedge clk) disable iff (!rst)
        start_i |-> (cmd_i.count != '0) && (cmd_i.count <= epu_pkg::BUF_DEPTH));

endmodule

// ==== logic/epu_axi_slave.sv ====
module epu_axi_slave (
    input  logic              clk,
    input  logic              rst,
    // Address channels
    input  epu_pkg::axi_ar_t  aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  epu_pkg::axi_ar_t  ar_i,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    // Write data and response
    input  epu_pkg::axi_w_t   w_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    output epu_pkg::axi_b_t   b_o,
    output logic              b_valid_o,
    input  logic              b_ready_i,
    // Read data
    output epu_pkg::axi_r_t   r_o,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    // Buffer side
    output epu_pkg::buf_req_t buf_req_o,
    output logic              in_sel_o,
    output logic              wt_sel_o,
    input  epu_pkg::data_t    in_rdata_i,
    input  epu_pkg::data_t    wt_rdata_i,
    // Engine side
    output epu_pkg::mac_cmd_t cmd_o,
    output logic              start_o,
    input  epu_pkg::acc_t     result_i,
    input  logic              busy_i,
    input  logic              done_i
);

    epu_pkg::slave_state_e state_q;
    epu_pkg::slave_state_e state_d;

    logic aw_hs;
    logic ar_hs;
    logic w_hs;
    logic r_hs;
    logic r_last;

    // Burst context, captured on the address handshake
    epu_pkg::id_t   id_q;
    epu_pkg::len_t  len_q;
    epu_pkg::len_t  beat_q;
    epu_pkg::addr_t addr_q;
    epu_pkg::addr_t hs_addr;
    epu_pkg::addr_t rd_addr;
    logic           in_hit_q;
    logic           wt_hit_q;
    logic           ctrl_hit_q;

    // Control registers
    epu_pkg::cnt_t  len_reg_q;
    logic           relu_q;
    logic           start_q;
    logic           reg_wr;
    epu_pkg::data_t reg_rdata;
    epu_pkg::data_t reg_rdata_q;

    // AW wins over AR when both arrive in S_IDLE
    assign aw_ready_o = state_q == epu_pkg::S_IDLE;
    assign ar_ready_o = (state_q == epu_pkg::S_IDLE) && !aw_valid_i;
    assign w_ready_o  = state_q == epu_pkg::S_WR;
    assign r_valid_o  = state_q == epu_pkg::S_RD;
    assign b_valid_o  = state_q == epu_pkg::S_RESP;

    assign aw_hs  = aw_valid_i && aw_ready_o;
    assign ar_hs  = ar_valid_i && ar_ready_o;
    assign w_hs   = w_valid_i && w_ready_o;
    assign r_hs   = r_valid_o && r_ready_i;
    assign r_last = beat_q == len_q;

    assign hs_addr = aw_hs ? aw_i.addr : ar_i.addr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= epu_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            epu_pkg::S_IDLE: begin
                if (aw_hs) begin
                    state_d = epu_pkg::S_WR;
                end else if (ar_hs) begin
                    state_d = epu_pkg::S_RD;
                end
            end
            epu_pkg::S_WR: begin
                if (w_hs && w_i.last) begin
                    state_d = epu_pkg::S_RESP;
                end
            end
            epu_pkg::S_RD: begin
                if (r_hs && r_last) begin
                    state_d = epu_pkg::S_IDLE;
                end
            end
            epu_pkg::S_RESP: begin
                if (b_ready_i) begin
                    state_d = epu_pkg::S_IDLE;
                end
            end
            default: state_d = epu_pkg::S_IDLE;
        endcase
    end

    // Region decode happens once, on the address handshake
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            id_q       <= '0;
            len_q      <= '0;
            beat_q     <= '0;
            addr_q     <= '0;
            in_hit_q   <= 1'b0;
            wt_hit_q   <= 1'b0;
            ctrl_hit_q <= 1'b0;
        end else if (aw_hs || ar_hs) begin
            id_q       <= aw_hs ? aw_i.id : ar_i.id;
            len_q      <= aw_hs ? aw_i.len : ar_i.len;
            beat_q     <= '0;
            addr_q     <= hs_addr;
            in_hit_q   <= (hs_addr & epu_pkg::REGION_MASK) == epu_pkg::IN_BASE;
            wt_hit_q   <= (hs_addr & epu_pkg::REGION_MASK) == epu_pkg::WT_BASE;
            ctrl_hit_q <= (hs_addr & epu_pkg::REGION_MASK) == epu_pkg::CTRL_BASE;
        end else if (w_hs || r_hs) begin
            beat_q <= beat_q + 8'd1;
            addr_q <= addr_q + 32'd4;
        end
    end

    // Look one word ahead on a read transfer so the next beat is ready a cycle later
    always_comb begin
        if (state_q == epu_pkg::S_RD) begin
            rd_addr = r_hs ? addr_q + 32'd4 : addr_q;
        end else begin
            rd_addr = ar_i.addr;
        end
    end

    assign buf_req_o.idx   = (state_q == epu_pkg::S_WR) ? addr_q[7:2] : rd_addr[7:2];
    assign buf_req_o.wdata = w_i.data;
    assign buf_req_o.we    = w_hs && !busy_i;
    assign in_sel_o        = in_hit_q;
    assign wt_sel_o        = wt_hit_q;

    assign reg_wr = w_hs && ctrl_hit_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            len_reg_q <= 7'd1;
            relu_q    <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (reg_wr && (addr_q[15:0] == epu_pkg::REG_LEN)) begin
                len_reg_q <= w_i.data[6:0];
            end
            if (reg_wr && (addr_q[15:0] == epu_pkg::REG_CTRL)) begin
                relu_q  <= w_i.data[epu_pkg::CTRL_RELU_BIT];
                // A start while a run is pending is dropped
                start_q <= w_i.data[epu_pkg::CTRL_START_BIT] && !busy_i && !start_q;
            end
        end
    end

    always_comb begin
        reg_rdata = '0;
        case (epu_pkg::reg_off_t'(rd_addr[15:0]))
            epu_pkg::REG_LEN:    reg_rdata = epu_pkg::data_t'(len_reg_q);
            epu_pkg::REG_CTRL:   reg_rdata[epu_pkg::CTRL_RELU_BIT] = relu_q;
            epu_pkg::REG_RESULT: reg_rdata = epu_pkg::data_t'(result_i);
            epu_pkg::REG_STATUS: begin
                reg_rdata[epu_pkg::STATUS_BUSY_BIT] = busy_i;
                reg_rdata[epu_pkg::STATUS_DONE_BIT] = done_i;
            end
            default: reg_rdata = '0;
        endcase
    end

    // Sampled once per beat so the word holds under back-pressure
    always_ff @(posedge clk) begin
        if (ar_hs || r_hs) begin
            reg_rdata_q <= reg_rdata;
        end
    end

    always_comb begin
        r_o.id   = id_q;
        r_o.last = r_last;
        r_o.resp = epu_pkg::RESP_OKAY;
        if (in_hit_q) begin
            r_o.data = in_rdata_i;
        end else if (wt_hit_q) begin
            r_o.data = wt_rdata_i;
        end else if (ctrl_hit_q) begin
            r_o.data = reg_rdata_q;
        end else begin
            r_o.data = '0;
        end
    end

    assign b_o.id   = id_q;
    assign b_o.resp = epu_pkg::RESP_OKAY;

    assign cmd_o.count = len_reg_q;
    assign cmd_o.relu  = relu_q;
    assign start_o     = start_q;

    // A buffer burst stays within the 64-word window
    a_burst_in_buf: assert property (@(posedge clk) disable iff (!rst)
        (state_q inside {epu_pkg::S_WR, epu_pkg::S_RD}) && (in_hit_q || wt_hit_q)
        |-> (addr_q[15:2] < epu_pkg::BUF_DEPTH));

    a_start_idle: assert property (@(posedge clk) disable iff (!rst)
        start_o |-> !busy_i);

endmodule

// ==== logic/epu_top.sv ====
module epu_top (
    input  logic              clk,
    input  logic              rst,
    // AXI4 slave port
    input  epu_pkg::axi_ar_t  aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  epu_pkg::axi_ar_t  ar_i,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    input  epu_pkg::axi_w_t   w_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    output epu_pkg::axi_r_t   r_o,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    output epu_pkg::axi_b_t   b_o,
    output logic              b_valid_o,
    input  logic              b_ready_i,
    // Completion interrupt
    output logic              epuint_o
);

    epu_pkg::buf_req_t buf_req;
    logic              in_sel;
    logic              wt_sel;
    epu_pkg::data_t    in_rdata;
    epu_pkg::data_t    wt_rdata;
    epu_pkg::buf_idx_t eng_idx;
    epu_pkg::data_t    in_eng_rdata;
    epu_pkg::data_t    wt_eng_rdata;
    epu_pkg::mac_cmd_t cmd;
    logic              start;
    epu_pkg::acc_t     result;
    logic              busy;
    logic              done;

    // Done level doubles as the interrupt
    assign epuint_o = done;

    epu_axi_slave u_slave (
        .clk        (clk),
        .rst        (rst),
        .aw_i       (aw_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .ar_i       (ar_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .w_i        (w_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .b_o        (b_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .r_o        (r_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .buf_req_o  (buf_req),
        .in_sel_o   (in_sel),
        .wt_sel_o   (wt_sel),
        .in_rdata_i (in_rdata),
        .wt_rdata_i (wt_rdata),
        .cmd_o      (cmd),
        .start_o    (start),
        .result_i   (result),
        .busy_i     (busy),
        .done_i     (done)
    );

    // Input activations
    epu_buffer u_in_buf (
        .clk         (clk),
        .sel_i       (in_sel),
        .req_i       (buf_req),
        .rdata_o     (in_rdata),
        .eng_idx_i   (eng_idx),
        .eng_rdata_o (in_eng_rdata)
    );

    // Weights
    epu_buffer u_wt_buf (
        .clk         (clk),
        .sel_i       (wt_sel),
        .req_i       (buf_req),
        .rdata_o     (wt_rdata),
        .eng_idx_i   (eng_idx),
        .eng_rdata_o (wt_eng_rdata)
    );

    mac_engine u_mac (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start),
        .cmd_i     (cmd),
        .idx_o     (eng_idx),
        .in_data_i (in_eng_rdata),
        .wt_data_i (wt_eng_rdata),
        .result_o  (result),
        .busy_o    (busy),
        .done_o    (done)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    localparam int HALF_PERIOD = 2;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

// ==== verif/epu_top_tb.sv ====
module epu_top_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int MAX_WORDS      = 64;

    // Channel codes for the handshake helper
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_B  = 2;
    localparam int CH_AR = 3;
    localparam int CH_R  = 4;

    logic             clk;
    logic             rst;
    epu_pkg::axi_ar_t aw;
    logic             aw_valid;
    logic             aw_ready;
    epu_pkg::axi_ar_t ar;
    logic             ar_valid;
    logic             ar_ready;
    epu_pkg::axi_w_t  w;
    logic             w_valid;
    logic             w_ready;
    epu_pkg::axi_r_t  r;
    logic             r_valid;
    logic             r_ready;
    epu_pkg::axi_b_t  b;
    logic             b_valid;
    logic             b_ready;
    logic             epuint;

    // Payloads captured on the handshake cycle
    epu_pkg::axi_r_t  r_seen;
    epu_pkg::axi_b_t  b_seen;

    logic [31:0] words [MAX_WORDS];
    logic [31:0] lcg_state = 32'hb50f;
    int          errors = 0;
    logic        aborted = 1'b0;

    tb_clock_gen u_clk (
        .clk_o (clk)
    );

    epu_top uut (
        .clk        (clk),
        .rst        (rst),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .b_o        (b),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .epuint_o   (epuint)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic channel_ready(input int ch);
        case (ch)
            CH_AW:   return aw_ready;
            CH_W:    return w_ready;
            CH_B:    return b_valid;
            CH_AR:   return ar_ready;
            default: return r_valid;
        endcase
    endfunction

    function automatic string channel_name(input int ch);
        case (ch)
            CH_AW:   return "write address";
            CH_W:    return "write data";
            CH_B:    return "write response";
            CH_AR:   return "read address";
            default: return "read data";
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: the %s gave no response within %0d cycles", what, TIMEOUT_CYCLES);
        errors++;
        aborted = 1'b1;
    endtask

    // Ready sampled at the falling edge, so the transfer is the next rising edge
    task automatic wait_handshake(input int ch);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && !aborted) begin
            @(negedge clk);
            seen   = channel_ready(ch);
            r_seen = r;
            b_seen = b;
            @(posedge clk);
            #1;
            cycles++;
            if (!seen && cycles >= TIMEOUT_CYCLES) begin
                report_timeout({channel_name(ch), " channel"});
            end
        end
    endtask

    task automatic axi_write_burst(input epu_pkg::addr_t addr, input int n,
                                   input epu_pkg::id_t id);
        aw.id    = id;
        aw.addr  = addr;
        aw.len   = epu_pkg::len_t'(n - 1);
        aw_valid = 1'b1;
        wait_handshake(CH_AW);
        aw_valid = 1'b0;
        if (aborted) return;
        for (int i = 0; i < n; i++) begin
            w.data  = words[i];
            w.last  = (i == n - 1);
            w_valid = 1'b1;
            wait_handshake(CH_W);
            if (aborted) return;
        end
        w_valid = 1'b0;
        w.last  = 1'b0;
        b_ready = 1'b1;
        wait_handshake(CH_B);
        b_ready = 1'b0;
        if (aborted) return;
        check_value(b_seen.id, id, "BID");
        check_value(b_seen.resp, epu_pkg::RESP_OKAY, "BRESP");
    endtask

    // Random one-cycle stalls on RREADY exercise back-pressure
    task automatic axi_read_burst(input epu_pkg::addr_t addr, input int n,
                                  input epu_pkg::id_t id);
        logic [31:0] rnd;
        ar.id    = id;
        ar.addr  = addr;
        ar.len   = epu_pkg::len_t'(n - 1);
        ar_valid = 1'b1;
        wait_handshake(CH_AR);
        ar_valid = 1'b0;
        if (aborted) return;
        for (int i = 0; i < n; i++) begin
            rnd = next_random();
            if (rnd[16]) begin
                @(posedge clk);
                #1;
            end
            r_ready = 1'b1;
            wait_handshake(CH_R);
            r_ready = 1'b0;
            if (aborted) return;
            check_value(r_seen.data, words[i], $sformatf("RDATA beat %0d from %h", i, addr));
            check_value(r_seen.id, id, "RID");
            check_value(r_seen.last, i == n - 1, $sformatf("RLAST beat %0d", i));
            check_value(r_seen.resp, epu_pkg::RESP_OKAY, "RRESP");
        end
    endtask

    task automatic run_engine(input int count, input logic relu, input logic [31:0] expected);
        int cycles;
        words[0] = count;
        axi_write_burst(epu_pkg::CTRL_BASE + epu_pkg::REG_LEN, 1, 4'h1);
        words[0] = {30'd0, relu, 1'b1};
        axi_write_burst(epu_pkg::CTRL_BASE + epu_pkg::REG_CTRL, 1, 4'h2);
        if (aborted) return;
        // Start clears the previous completion
        check_value(epuint, 1'b0, "interrupt after start");
        cycles = 0;
        while (!epuint && !aborted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!epuint && cycles >= TIMEOUT_CYCLES) begin
                report_timeout("engine interrupt");
            end
        end
        if (aborted) return;
        words[0] = 32'h2;
        axi_read_burst(epu_pkg::CTRL_BASE + epu_pkg::REG_STATUS, 1, 4'h3);
        words[0] = expected;
        axi_read_burst(epu_pkg::CTRL_BASE + epu_pkg::REG_RESULT, 1, 4'h4);
    endtask

    initial begin
        int             fd;
        int             code;
        int             n;
        int             count;
        int             relu;
        int             case_no;
        int             passed;
        int             failed;
        int             errors_before;
        logic [63:0]    tok;
        logic [1023:0]  line;
        logic [31:0]    addr;
        logic [31:0]    value;
        string          what;

        rst      = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        r_ready  = 1'b0;
        b_ready  = 1'b0;
        case_no  = 0;
        passed   = 0;
        failed   = 0;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        check_value(aw_ready, 1'b1, "AWREADY after reset");
        check_value(ar_ready, 1'b1, "ARREADY after reset");
        check_value(epuint, 1'b0, "interrupt after reset");
        @(posedge clk);
        #1;

        fd = $fopen("verif/epu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verif/epu_cases.txt");
            errors++;
        end

        while (fd != 0 && !aborted && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(line, fd);
            end else begin
                errors_before = errors;
                if (tok == "W" || tok == "R") begin
                    code = $fscanf(fd, "%h %d", addr, n);
                    for (int i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%h", value);
                        words[i] = value;
                    end
                    if (tok == "W") begin
                        what = $sformatf("write %0d words at %h", n, addr);
                        axi_write_burst(addr, n, epu_pkg::id_t'(case_no));
                    end else begin
                        what = $sformatf("read %0d words at %h", n, addr);
                        axi_read_burst(addr, n, epu_pkg::id_t'(case_no));
                    end
                end else if (tok == "X") begin
                    code = $fscanf(fd, "%d %d %h", count, relu, value);
                    what = $sformatf("run count %0d relu %0d", count, relu);
                    run_engine(count, relu[0], value);
                end else begin
                    what = "unknown operation";
                    $display("The case file holds an operation that is not W, R or X");
                    errors++;
                end
                case_no++;
                if (errors == errors_before) begin
                    passed++;
                    $display("case %0d: %s ok", case_no, what);
                end else begin
                    failed++;
                    $display("case %0d: %s had mismatches", case_no, what);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("cases: %0d passed, %0d failed", passed, failed);
        if (errors == 0 && case_no > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== epu_top.f ====
logic/epu_pkg.sv
logic/epu_buffer.sv
logic/mac_engine.sv
logic/epu_axi_slave.sv
logic/epu_top.sv
verif/tb_clock_gen.sv
verif/epu_top_tb.sv

// ==== Makefile ====
TOP  := epu_top_tb
SRCS := $(wildcard logic/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): epu_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f epu_top.f -Mdir obj_dir -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== verif/epu_cases.txt ====
# W addr nwords data...  write burst of nwords words
# R addr nwords data...  read burst, data are the expected words
# X count relu result    run the engine, result is the expected REG_RESULT
# input activations, upper halves are ignored by the engine
W 50000000 8 00000003 ABCD0005 0000FFFE 00000007 0000FFFF 00000010 00007FFF 00000002
# weights
W 70000000 8 00000002 0000FFFD 00000004 12340001 00000006 0000FFF8 00007FFF 00000009
R 50000000 8 00000003 ABCD0005 0000FFFE 00000007 0000FFFF 00000010 00007FFF 00000002
R 70000000 8 00000002 0000FFFD 00000004 12340001 00000006 0000FFF8 00007FFF 00000009
# two more elements whose products push the sum past the signed range
W 50000020 2 00008000 00008000
W 70000020 2 00008000 00008000
R 50000020 2 00008000 00008000
R 70000020 2 00008000 00008000
# unmapped regions read as zero
R 60000000 4 00000000 00000000 00000000 00000000
R 80010000 2 00000000 00000000
# unmapped writes that would hit index 0 if the decode ignored the upper bits
W 50010000 2 DEADBEEF CAFEF00D
W 70010000 1 12345678
W 40000000 1 87654321
R 50000000 2 00000003 ABCD0005
R 70000000 2 00000002 0000FFFD
# engine runs
X 1 0 00000006
X 2 0 FFFFFFF7
X 3 1 00000000
X 4 0 FFFFFFF6
X 4 1 00000000
X 6 0 FFFFFF70
X 8 1 3FFEFF83
X 10 0 BFFEFF83
X 10 1 00000000
X 1 1 00000006
# length and relu registers read back
R 80000000 1 00000001
R 80000004 1 00000002
# buffers still hold their words after the runs
R 50000000 1 00000003
R 70000024 1 00008000
